/* common/raster_settings.svh */
// Global sizes of the rasterizer
// Screen resolution, bus and word widths, payload counts

`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

////////////////////////////////////////
// Screen
////////////////////////////////////////
`define X_RESOLUTION 16
`define Y_RESOLUTION 16

////////////////////////////////////////
// Word widths
////////////////////////////////////////
`define CMD_WIDTH 32
`define PIXEL_WIDTH 16
`define FB_INDEX_WIDTH 8

// bbStart, bbEnd and three each of w, wIncX, wIncY
`define TRIANGLE_PARAM_WORDS 11

`endif

/* common/rasterPkg.sv */
// Shared types of the rasterizer
// Opcode and register enums, pixel and index types,
// triangle and configuration structs, memory request, FSM states

`include "raster_settings.svh"

package rasterPkg;

    typedef enum logic [3:0] {
        OpNop      = 4'd0,
        OpSetReg   = 4'd1,
        OpTriangle = 4'd2,
        OpClear    = 4'd3,
        OpCommit   = 4'd4
    } opCodeT;

    typedef enum logic [3:0] {
        RegClearColor    = 4'd0,
        RegTriangleColor = 4'd1,
        RegScissorStart  = 4'd2,
        RegScissorEnd    = 4'd3,
        RegFeatureEnable = 4'd4
    } regIndexT;

    typedef logic [`PIXEL_WIDTH-1:0] pixelT;
    typedef logic [`FB_INDEX_WIDTH-1:0] fbIndexT;
    typedef logic signed [31:0] edgeT;

    // y in the upper half of the word
    typedef struct packed {
        logic [15:0] y;
        logic [15:0] x;
    } screenPosT;

    // First payload word sits in the top bits
    typedef struct packed {
        screenPosT   bbStart;
        screenPosT   bbEnd;
        edgeT [0:2]  w;
        edgeT [0:2]  wIncX;
        edgeT [0:2]  wIncY;
    } triangleParamsT;

    typedef struct packed {
        pixelT     clearColor;
        pixelT     triangleColor;
        screenPosT scissorStart;
        screenPosT scissorEnd;
        logic      scissorEnable;
    } configRegsT;

    typedef struct packed {
        logic    write;
        logic    read;
        fbIndexT index;
        pixelT   data;
    } bufferReqT;

    typedef enum logic [2:0] {PsHeader, PsRegValue, PsTriangle, PsStart, PsWait} parserStateT;
    typedef enum logic {RsIdle, RsRun} rasterStateT;
    typedef enum logic [1:0] {SwIdle, SwClear, SwCommit} sweepStateT;

endpackage

/* hw/commandParser.sv */
// Command stream decoder
// Configuration bank, triangle parameter register,
// start pulses and stall until the started unit is idle

`timescale 1ns/1ns
`include "raster_settings.svh"

module commandParser (
    input  logic                      aclk,
    input  logic                      arstN,
    input  logic                      cmdValid,
    output logic                      cmdReady,
    input  logic [`CMD_WIDTH-1:0]     cmdData,
    output rasterPkg::configRegsT     configRegs,
    output rasterPkg::triangleParamsT triangle,
    output logic                      startRendering,
    output logic                      startClear,
    output logic                      startCommit,
    input  logic                      rasterizerRunning,
    input  logic                      sweepBusy
);
    import rasterPkg::*;

    parserStateT    state;
    opCodeT         pendingOp;
    regIndexT       regIndex;
    logic [3:0]     wordCount;
    logic           cmdXfer;
    triangleParamsT triangleReg;

    assign cmdReady = (state == PsHeader) || (state == PsRegValue) || (state == PsTriangle);
    assign cmdXfer = cmdValid && cmdReady;

    assign startRendering = (state == PsStart) && (pendingOp == OpTriangle);
    assign startClear     = (state == PsStart) && (pendingOp == OpClear);
    assign startCommit    = (state == PsStart) && (pendingOp == OpCommit);
    assign triangle = triangleReg;

    ////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////
    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            state     <= PsHeader;
            pendingOp <= OpNop;
            regIndex  <= RegClearColor;
            wordCount <= '0;
        end else begin
            case (state)
                PsHeader: begin
                    if (cmdXfer) begin
                        pendingOp <= opCodeT'(cmdData[`CMD_WIDTH-1 -: 4]);
                        regIndex  <= regIndexT'(cmdData[3:0]);
                        wordCount <= '0;
                        case (opCodeT'(cmdData[`CMD_WIDTH-1 -: 4]))
                            OpSetReg:          state <= PsRegValue;
                            OpTriangle:        state <= PsTriangle;
                            OpClear, OpCommit: state <= PsStart;
                            default:           state <= PsHeader;
                        endcase
                    end
                end
                PsRegValue: begin
                    if (cmdXfer) begin
                        state <= PsHeader;
                    end
                end
                PsTriangle: begin
                    if (cmdXfer) begin
                        wordCount <= wordCount + 4'd1;
                        if (wordCount == 4'(`TRIANGLE_PARAM_WORDS - 1)) begin
                            state <= PsStart;
                        end
                    end
                end
                PsStart: state <= PsWait;
                default: begin
                    if (!rasterizerRunning && !sweepBusy) begin
                        state <= PsHeader;
                    end
                end
            endcase
        end
    end

    // Register bank, unknown indices fall through
    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            configRegs <= '0;
        end else if ((state == PsRegValue) && cmdXfer) begin
            case (regIndex)
                RegClearColor:    configRegs.clearColor <= cmdData[`PIXEL_WIDTH-1:0];
                RegTriangleColor: configRegs.triangleColor <= cmdData[`PIXEL_WIDTH-1:0];
                RegScissorStart:  configRegs.scissorStart <= cmdData;
                RegScissorEnd:    configRegs.scissorEnd <= cmdData;
                RegFeatureEnable: configRegs.scissorEnable <= cmdData[0];
                default: ;
            endcase
        end
    end

    // Payload words shift in from the bottom
    always_ff @(posedge aclk) begin
        if ((state == PsTriangle) && cmdXfer) begin
            triangleReg <= {triangleReg[$bits(triangleParamsT)-`CMD_WIDTH-1:0], cmdData};
        end
    end

    // Units must be idle whenever a new operation is launched
    assert property (@(posedge aclk) disable iff (!arstN)
        (startRendering || startClear || startCommit) |-> !(rasterizerRunning || sweepBusy));

endmodule

/* hw/rasterizer/rasterizer.sv */
// Edge-function rasterizer
// Bounding box walk, edge stepping in x and y,
// coverage and scissor test, pixel writes to the color buffer

`timescale 1ns/1ns
`include "raster_settings.svh"

module rasterizer (
    input  logic                      aclk,
    input  logic                      arstN,
    input  logic                      startRendering,
    input  rasterPkg::triangleParamsT triangle,
    input  rasterPkg::configRegsT     configRegs,
    output logic                      rasterizerRunning,
    output rasterPkg::bufferReqT      rasterReq,
    input  logic                      rasterGrant
);
    import rasterPkg::*;

    rasterStateT state;
    logic [15:0] x;
    logic [15:0] y;
    edgeT        w [3];
    edgeT        rowW [3];
    logic        inBox;
    logic        covered;
    logic        inScissor;
    logic        advance;

    assign inBox = (x < triangle.bbEnd.x) && (y < triangle.bbEnd.y);
    assign covered = (w[0] >= 0) && (w[1] >= 0) && (w[2] >= 0);
    assign inScissor = !configRegs.scissorEnable
        || ((x >= configRegs.scissorStart.x) && (x < configRegs.scissorEnd.x)
            && (y >= configRegs.scissorStart.y) && (y < configRegs.scissorEnd.y));

    assign rasterizerRunning = (state == RsRun);
    assign rasterReq.write = rasterizerRunning && inBox && covered && inScissor;
    assign rasterReq.read  = 1'b0;
    assign rasterReq.index = fbIndexT'(y * `X_RESOLUTION + x);
    assign rasterReq.data  = configRegs.triangleColor;

    // Uncovered pixels step on without the memory
    assign advance = !rasterReq.write || rasterGrant;

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            state <= RsIdle;
        end else if (state == RsIdle) begin
            if (startRendering) begin
                state <= RsRun;
            end
        end else if (!inBox) begin
            state <= RsIdle;
        end
    end

    ////////////////////////////////////////
    // Box walk
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (startRendering) begin
            x <= triangle.bbStart.x;
            y <= triangle.bbStart.y;
            for (int i = 0; i < 3; i++) begin
                w[i]    <= triangle.w[i];
                rowW[i] <= triangle.w[i];
            end
        end else if (rasterizerRunning && inBox && advance) begin
            if ((x + 16'd1) < triangle.bbEnd.x) begin
                x <= x + 16'd1;
                for (int i = 0; i < 3; i++) begin
                    w[i] <= w[i] + triangle.wIncX[i];
                end
            end else begin
                // Next row restarts from the saved row value
                x <= triangle.bbStart.x;
                y <= y + 16'd1;
                for (int i = 0; i < 3; i++) begin
                    rowW[i] <= rowW[i] + triangle.wIncY[i];
                    w[i]    <= rowW[i] + triangle.wIncY[i];
                end
            end
        end
    end

    // Stalled write holds its pixel until granted
    assert property (@(posedge aclk) disable iff (!arstN)
        (rasterReq.write && !rasterGrant)
            |=> (rasterizerRunning && rasterReq.write && $stable(rasterReq.index)));

    assert property (@(posedge aclk) disable iff (!arstN)
        $rose(rasterizerRunning)
            |-> ((triangle.bbEnd.x <= `X_RESOLUTION) && (triangle.bbEnd.y <= `Y_RESOLUTION)));

endmodule

/* hw/framebuffer/colorBuffer.sv */
// Framebuffer pixel RAM
// Fixed-priority arbiter, sweep port ahead of the rasterizer,
// registered read port

`timescale 1ns/1ns
`include "raster_settings.svh"

module colorBuffer (
    input  logic                 aclk,
    input  logic                 arstN,
    input  rasterPkg::bufferReqT rasterReq,
    input  rasterPkg::bufferReqT sweepReq,
    output logic                 rasterGrant,
    output logic                 sweepGrant,
    output rasterPkg::pixelT     readPixel
);
    import rasterPkg::*;

    localparam int fbDepth = `X_RESOLUTION * `Y_RESOLUTION;

    pixelT     mem [fbDepth];
    bufferReqT selReq;

    ////////////////////////////////////////
    // Arbiter
    ////////////////////////////////////////
    assign sweepGrant  = sweepReq.write || sweepReq.read;
    assign rasterGrant = (rasterReq.write || rasterReq.read) && !sweepGrant;
    assign selReq = sweepGrant ? sweepReq : rasterReq;

    always_ff @(posedge aclk) begin
        if (selReq.write) begin
            mem[selReq.index] <= selReq.data;
        end
        // Data valid one cycle after the granted read
        if (selReq.read) begin
            readPixel <= mem[selReq.index];
        end
    end

    // One operation per request on either port
    assert property (@(posedge aclk) disable iff (!arstN)
        !(sweepReq.write && sweepReq.read) && !(rasterReq.write && rasterReq.read));

endmodule

/* hw/framebuffer/bufferSweep.sv */
// Full-buffer sweep unit
// Clear writes the clear color everywhere,
// commit reads every pixel out through a two-entry holding register

`timescale 1ns/1ns
`include "raster_settings.svh"

module bufferSweep (
    input  logic                 aclk,
    input  logic                 arstN,
    input  logic                 startClear,
    input  logic                 startCommit,
    input  rasterPkg::pixelT     clearColor,
    output logic                 sweepBusy,
    output rasterPkg::bufferReqT sweepReq,
    input  logic                 sweepGrant,
    input  rasterPkg::pixelT     readPixel,
    output logic                 fbValid,
    output rasterPkg::pixelT     fbData,
    output logic                 fbLast,
    input  logic                 fbReady
);
    import rasterPkg::*;

    sweepStateT               state;
    logic [`FB_INDEX_WIDTH:0] sweepIdx;
    logic                     sweepDone;
    logic                     readInFlight;
    logic                     readLast;
    logic [1:0]               holdCount;
    pixelT                    holdData [2];
    logic                     holdLast [2];
    logic                     pop;

    assign sweepDone = sweepIdx[`FB_INDEX_WIDTH];
    assign sweepBusy = (state != SwIdle);
    assign fbValid = (holdCount != 2'd0);
    assign fbData  = holdData[0];
    assign fbLast  = holdLast[0];
    assign pop = fbValid && fbReady;

    assign sweepReq.write = (state == SwClear) && !sweepDone;
    // Issue only if the holding register has room when the data lands
    assign sweepReq.read = (state == SwCommit) && !sweepDone
        && ((holdCount + 2'(readInFlight) - 2'(pop)) < 2'd2);
    assign sweepReq.index = sweepIdx[`FB_INDEX_WIDTH-1:0];
    assign sweepReq.data  = clearColor;

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            state        <= SwIdle;
            sweepIdx     <= '0;
            readInFlight <= 1'b0;
            holdCount    <= 2'd0;
        end else begin
            readInFlight <= sweepReq.read && sweepGrant;
            holdCount    <= holdCount + 2'(readInFlight) - 2'(pop);
            if ((sweepReq.write || sweepReq.read) && sweepGrant) begin
                sweepIdx <= sweepIdx + 1'b1;
            end
            case (state)
                SwIdle: begin
                    sweepIdx <= '0;
                    if (startClear) begin
                        state <= SwClear;
                    end else if (startCommit) begin
                        state <= SwCommit;
                    end
                end
                SwClear: begin
                    if (sweepDone) begin
                        state <= SwIdle;
                    end
                end
                default: begin
                    if (pop && fbLast) begin
                        state <= SwIdle;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Holding register
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        readLast <= &sweepReq.index;
        if (pop) begin
            holdData[0] <= holdData[1];
            holdLast[0] <= holdLast[1];
        end
        if (readInFlight) begin
            if ((holdCount == 2'd0) || ((holdCount == 2'd1) && pop)) begin
                holdData[0] <= readPixel;
                holdLast[0] <= readLast;
            end else begin
                holdData[1] <= readPixel;
                holdLast[1] <= readLast;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!arstN)
        (fbValid && !fbReady) |=> (fbValid && $stable(fbData) && $stable(fbLast)));

endmodule

/* hw/rasterixTop.sv */
// Rasterizer top level
// Command parser, rasterizer, sweep unit and color buffer

`timescale 1ns/1ns
`include "raster_settings.svh"

module rasterixTop (
    input  logic                  aclk,
    input  logic                  arstN,
    input  logic                  cmdValid,
    output logic                  cmdReady,
    input  logic [`CMD_WIDTH-1:0] cmdData,
    output logic                  fbValid,
    input  logic                  fbReady,
    output rasterPkg::pixelT      fbData,
    output logic                  fbLast
);
    import rasterPkg::*;

    configRegsT     configRegs;
    triangleParamsT triangle;
    logic           startRendering;
    logic           startClear;
    logic           startCommit;
    logic           rasterizerRunning;
    logic           sweepBusy;
    bufferReqT      rasterReq;
    bufferReqT      sweepReq;
    logic           rasterGrant;
    logic           sweepGrant;
    pixelT          readPixel;

    commandParser parser0 (
        .aclk(aclk), .arstN(arstN),
        .cmdValid(cmdValid), .cmdReady(cmdReady), .cmdData(cmdData),
        .configRegs(configRegs), .triangle(triangle),
        .startRendering(startRendering), .startClear(startClear), .startCommit(startCommit),
        .rasterizerRunning(rasterizerRunning), .sweepBusy(sweepBusy)
    );

    rasterizer raster0 (
        .aclk(aclk), .arstN(arstN),
        .startRendering(startRendering), .triangle(triangle), .configRegs(configRegs),
        .rasterizerRunning(rasterizerRunning), .rasterReq(rasterReq), .rasterGrant(rasterGrant)
    );

    bufferSweep sweep0 (
        .aclk(aclk), .arstN(arstN),
        .startClear(startClear), .startCommit(startCommit),
        .clearColor(configRegs.clearColor), .sweepBusy(sweepBusy),
        .sweepReq(sweepReq), .sweepGrant(sweepGrant), .readPixel(readPixel),
        .fbValid(fbValid), .fbData(fbData), .fbLast(fbLast), .fbReady(fbReady)
    );

    colorBuffer colorBuffer0 (
        .aclk(aclk), .arstN(arstN),
        .rasterReq(rasterReq), .sweepReq(sweepReq),
        .rasterGrant(rasterGrant), .sweepGrant(sweepGrant), .readPixel(readPixel)
    );

endmodule

/* verification/rasterixTb.sv */
// Testbench for the rasterizer top level
// Step table of clears, triangles and commits applied in a loop,
// reference image model, pixel and flag compare tasks,
// LCG back-pressure on the pixel output, cycle watchdog

`timescale 1ns/1ns
`include "raster_settings.svh"

module rasterixTb;
    import rasterPkg::*;

    localparam int NumPixels = `X_RESOLUTION * `Y_RESOLUTION;
    localparam int NumSteps = 10;

    typedef enum logic [1:0] {StepClear, StepTriangle, StepCommit} stepKindT;

    // Edge i is a[i]*x + b[i]*y + c[i]
    // Box and scissor as x0, y0, x1, y1
    typedef struct packed {
        stepKindT         kind;
        logic             randomReady;
        pixelT            color;
        logic [0:3][31:0] box;
        logic [0:2][31:0] a;
        logic [0:2][31:0] b;
        logic [0:2][31:0] c;
        logic             scissorEnable;
        logic [0:3][31:0] scissor;
    } stepT;

    logic                  aclk;
    logic                  arstN;
    logic                  cmdValid;
    logic                  cmdReady;
    logic [`CMD_WIDTH-1:0] cmdData;
    logic                  fbValid;
    logic                  fbReady;
    pixelT                 fbData;
    logic                  fbLast;

    stepT        steps [NumSteps];
    pixelT       model [NumPixels];
    logic [31:0] lcgState = 32'd67;
    int          pixelCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          pixelErrors = 0;
    int          flagErrors = 0;
    int          streamErrors = 0;

    rasterixTop dut0 (
        .aclk(aclk), .arstN(arstN),
        .cmdValid(cmdValid), .cmdReady(cmdReady), .cmdData(cmdData),
        .fbValid(fbValid), .fbReady(fbReady), .fbData(fbData), .fbLast(fbLast)
    );

    always #4 aclk = ~aclk;

    always @(posedge aclk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, %0d of %0d pixels of the current commit seen",
                cycleCount, pixelCount, NumPixels);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic int edgeValue(input stepT st, input int i, input int x, input int y);
        return $signed(st.a[i]) * x + $signed(st.b[i]) * y + $signed(st.c[i]);
    endfunction

    function automatic logic [31:0] regHeader(input regIndexT idx);
        return {OpSetReg, 24'd0, idx};
    endfunction

    function automatic logic [31:0] opHeader(input opCodeT op);
        return {op, 28'd0};
    endfunction

    // y in the upper half
    function automatic logic [31:0] position(input logic [31:0] x, input logic [31:0] y);
        return {y[15:0], x[15:0]};
    endfunction

    function automatic stepT makeClear(input pixelT color);
        stepT st;
        st = '0;
        st.kind = StepClear;
        st.color = color;
        return st;
    endfunction

    function automatic stepT makeCommit(input logic randomReady);
        stepT st;
        st = '0;
        st.kind = StepCommit;
        st.randomReady = randomReady;
        return st;
    endfunction

    function automatic stepT makeTriangle(input pixelT color, input logic [0:3][31:0] box,
            input logic [0:2][31:0] a, input logic [0:2][31:0] b, input logic [0:2][31:0] c,
            input logic scissorEnable, input logic [0:3][31:0] scissor);
        stepT st;
        st = '0;
        st.kind = StepTriangle;
        st.color = color;
        st.box = box;
        st.a = a;
        st.b = b;
        st.c = c;
        st.scissorEnable = scissorEnable;
        st.scissor = scissor;
        return st;
    endfunction

    function automatic int stepWords(input stepT st);
        case (st.kind)
            StepClear:    return 3;
            StepTriangle: return 9 + `TRIANGLE_PARAM_WORDS;
            default:      return 1;
        endcase
    endfunction

    function automatic logic nextReadyBit();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[16];
    endfunction

    task automatic checkPixel(input string sigName, input pixelT expected, input pixelT actual);
        if (actual !== expected) begin
            pixelErrors++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, sigName, expected, actual);
        end
    endtask

    task automatic checkLast(input string sigName, input logic expected, input logic actual);
        if (actual !== expected) begin
            flagErrors++;
            $display("[ERROR] %0t ns: %s expected %b, got %b", $time, sigName, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////
    // Starts right after a rising edge
    // Returns once the word has transferred
    task automatic sendWord(input logic [31:0] word);
        logic accepted;
        cmdValid <= 1'b1;
        cmdData  <= word;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge aclk);
            accepted = cmdReady;
            @(posedge aclk);
        end
    endtask

    task automatic paintTriangle(input stepT st);
        logic inScissor;
        for (int y = st.box[1]; y < st.box[3]; y++) begin
            for (int x = st.box[0]; x < st.box[2]; x++) begin
                inScissor = !st.scissorEnable
                    || ((x >= st.scissor[0]) && (x < st.scissor[2])
                        && (y >= st.scissor[1]) && (y < st.scissor[3]));
                if (inScissor && (edgeValue(st, 0, x, y) >= 0)
                        && (edgeValue(st, 1, x, y) >= 0) && (edgeValue(st, 2, x, y) >= 0)) begin
                    model[y * `X_RESOLUTION + x] = st.color;
                end
            end
        end
    endtask

    task automatic receiveImage(input logic randomReady);
        logic readyBit;
        logic settled;
        pixelCount = 0;
        while (pixelCount < NumPixels) begin
            readyBit = randomReady ? nextReadyBit() : 1'b1;
            fbReady <= readyBit;
            @(negedge aclk);
            if (fbValid && fbReady) begin
                checkPixel($sformatf("fbData[%0d]", pixelCount), model[pixelCount], fbData);
                checkLast("fbLast", pixelCount == NumPixels - 1, fbLast);
                pixelCount++;
            end
            @(posedge aclk);
        end
        // Nothing may follow the last pixel
        fbReady <= 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(negedge aclk);
            if (fbValid) begin
                streamErrors++;
                $display("Extra pixel %h after the last one at %0t ns", fbData, $time);
            end
            @(posedge aclk);
        end
        // Parser takes commands again once the sweep is idle
        settled = 1'b0;
        while (!settled) begin
            @(negedge aclk);
            settled = cmdReady;
            @(posedge aclk);
        end
        fbReady <= 1'b0;
    endtask

    task automatic applyStep(input stepT st);
        case (st.kind)
            StepClear: begin
                sendWord(regHeader(RegClearColor));
                sendWord({16'd0, st.color});
                sendWord(opHeader(OpClear));
                cmdValid <= 1'b0;
                for (int i = 0; i < NumPixels; i++) begin
                    model[i] = st.color;
                end
            end
            StepTriangle: begin
                sendWord(regHeader(RegTriangleColor));
                sendWord({16'd0, st.color});
                sendWord(regHeader(RegScissorStart));
                sendWord(position(st.scissor[0], st.scissor[1]));
                sendWord(regHeader(RegScissorEnd));
                sendWord(position(st.scissor[2], st.scissor[3]));
                sendWord(regHeader(RegFeatureEnable));
                sendWord({31'd0, st.scissorEnable});
                sendWord(opHeader(OpTriangle));
                sendWord(position(st.box[0], st.box[1]));
                sendWord(position(st.box[2], st.box[3]));
                for (int i = 0; i < 3; i++) begin
                    sendWord(edgeValue(st, i, st.box[0], st.box[1]));
                end
                for (int i = 0; i < 3; i++) begin
                    sendWord(st.a[i]);
                end
                for (int i = 0; i < 3; i++) begin
                    sendWord(st.b[i]);
                end
                cmdValid <= 1'b0;
                paintTriangle(st);
            end
            default: begin
                sendWord(opHeader(OpCommit));
                cmdValid <= 1'b0;
                receiveImage(st.randomReady);
            end
        endcase
    endtask

    initial begin
        aclk = 1'b0;
        arstN    <= 1'b0;
        cmdValid <= 1'b0;
        cmdData  <= '0;
        fbReady  <= 1'b0;
        for (int i = 0; i < NumPixels; i++) begin
            model[i] = '0;
        end

        steps[0] = makeClear(16'h2945);
        steps[1] = makeCommit(1'b0);
        // Right triangle x >= 2, y >= 1, x + y <= 14
        steps[2] = makeTriangle(16'hF800, {32'd2, 32'd1, 32'd13, 32'd12},
            {32'd1, 32'd0, -32'd1}, {32'd0, 32'd1, -32'd1}, {-32'd2, -32'd1, 32'd14},
            1'b0, '0);
        steps[3] = makeCommit(1'b0);
        // Full-screen box, clipped by the scissor
        steps[4] = makeTriangle(16'h07E0, {32'd0, 32'd0, 32'd16, 32'd16},
            {32'd2, 32'd0, -32'd1}, {-32'd1, 32'd1, -32'd2}, {32'd0, -32'd3, 32'd30},
            1'b1, {32'd4, 32'd4, 32'd10, 32'd9});
        steps[5] = makeCommit(1'b0);
        steps[6] = makeTriangle(16'h001F, {32'd3, 32'd3, 32'd15, 32'd15},
            {32'd1, -32'd1, -32'd1}, {-32'd1, 32'd1, -32'd1}, {32'd3, 32'd3, 32'd20},
            1'b0, '0);
        steps[7] = makeCommit(1'b1);
        steps[8] = makeClear(16'hFFFF);
        steps[9] = makeCommit(1'b1);

        for (int s = 0; s < NumSteps; s++) begin
            cycleLimit += stepWords(steps[s]) + 1024;
        end

        repeat (3) @(posedge aclk);
        arstN <= 1'b1;
        @(negedge aclk);
        checkLast("fbValid", 1'b0, fbValid);
        checkLast("cmdReady", 1'b1, cmdReady);
        @(posedge aclk);

        for (int s = 0; s < NumSteps; s++) begin
            applyStep(steps[s]);
        end

        $display("Errors: %0d pixel, %0d flag, %0d stream", pixelErrors, flagErrors,
            streamErrors);
        if (pixelErrors + flagErrors + streamErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/rasterPkg.sv
hw/commandParser.sv
hw/rasterizer/rasterizer.sv
hw/framebuffer/colorBuffer.sv
hw/framebuffer/bufferSweep.sv
hw/rasterixTop.sv
verification/rasterixTb.sv

/* Makefile */
# Verilator build and run of the rasterizer testbench

VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = rasterixTb
FILELIST  = files.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
